// File: adp_bus_engine.sv
//------------------------------------------------
// Bus engine: executes one command, holds the
// address and GPO registers, runs AHB transfers
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module adp_bus_engine (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  input  wire adp_pkg::adp_cmd_t   cmd_i,
  input  wire                      cmd_stb_i,
  input  wire ahb_pkg::ahb_s2m_t   ahb_i,
  input  wire adp_pkg::gpio_t      gpi_i,
  output ahb_pkg::ahb_m2s_t        ahb_o,
  output adp_pkg::gpio_t           gpo_o,
  output adp_pkg::adp_rsp_t        rsp_o,
  output logic                     rsp_stb_o
);
  import ahb_pkg::*;
  import adp_pkg::*;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, REPORT} state_e;

  state_e   state_q;
  haddr_t   addr_q;
  gpio_t    gpo_q;
  gpio_t    gpo_next;
  ctl_sel_t ctl_sel;
  adp_rsp_t rsp_q;
  logic     bus_op;
  logic     data_done;

  assign bus_op    = (cmd_i.op == OP_R) || (cmd_i.op == OP_W);
  assign data_done = (state_q == DATA) && ahb_i.hready;
  assign ctl_sel   = cmd_i.param[31:8];

  // GPO update for the C command
  always_comb begin
    gpo_next = gpo_q;
    if (cmd_i.has_param) begin
      case (ctl_sel)
        24'd1:   gpo_next = gpo_q & ~cmd_i.param[7:0];  // clear
        24'd2:   gpo_next = gpo_q | cmd_i.param[7:0];   // set
        24'd3:   gpo_next = cmd_i.param[7:0];           // overwrite
        default: gpo_next = gpo_q;                      // report only
      endcase
    end
  end

  //------------------------------------------------
  // AHB initiator outputs
  //------------------------------------------------
  always_comb begin
    ahb_o.haddr     = addr_q;
    ahb_o.htrans    = (state_q == ADDR) ? NONSEQ : ahb_pkg::IDLE;
    ahb_o.hwrite    = (cmd_i.op == OP_W);
    ahb_o.hsize     = HSIZE_WORD;
    ahb_o.hburst    = 3'b000;  // SINGLE
    ahb_o.hprot     = HPROT_DATA;
    ahb_o.hmastlock = 1'b0;
    ahb_o.hwdata    = cmd_i.param;  // sampled in the data phase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= IDLE;
      addr_q  <= '0;
      gpo_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_stb_i) begin
            state_q <= bus_op ? ADDR : REPORT;
            if ((cmd_i.op == OP_A) && cmd_i.has_param)
              addr_q <= cmd_i.param;
            if (cmd_i.op == OP_C)
              gpo_q <= gpo_next;
          end
        end
        ADDR: begin
          if (ahb_i.hready)  // address phase taken
            state_q <= DATA;
        end
        DATA: begin
          if (data_done) begin
            state_q <= REPORT;
            addr_q  <= addr_q + ADDR_STEP;  // advances on error too
          end
        end
        REPORT:  state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // report word, held until the next strobe
  always_ff @(posedge HCLK) begin
    if ((state_q == IDLE) && cmd_stb_i) begin
      rsp_q.letter <= (cmd_i.op == OP_BAD) ? CH_UNKNOWN : cmd_i.letter;
      rsp_q.err    <= 1'b0;
      case (cmd_i.op)
        OP_A:    rsp_q.word <= cmd_i.has_param ? cmd_i.param : addr_q;
        OP_C:    rsp_q.word <= {gpi_i, gpo_next, cmd_i.param[15:0]};
        OP_W:    rsp_q.word <= cmd_i.param;
        default: rsp_q.word <= '0;
      endcase
    end else if (data_done) begin
      rsp_q.err <= ahb_i.hresp;
      if (cmd_i.op == OP_R)
        rsp_q.word <= ahb_i.hrdata;
    end
  end

  assign gpo_o     = gpo_q;
  assign rsp_o     = rsp_q;
  assign rsp_stb_o = (state_q == REPORT);

endmodule

`default_nettype wire

// File: adp_chk.sv
//------------------------------------------------
// Bus and byte stream rule checks for the debug
// protocol controller, bound into adp_top
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module adp_chk (
  input wire                    HCLK,
  input wire                    HRESETn,
  input wire ahb_pkg::ahb_m2s_t ahb_m2s_i,
  input wire ahb_pkg::ahb_s2m_t ahb_s2m_i,
  input wire adp_pkg::char_t    tx_data_i,
  input wire                    tx_valid_i,
  input wire                    tx_ready_i
);
  import ahb_pkg::*;

  // single transfers only
  htrans_legal_a: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (ahb_m2s_i.htrans == IDLE) || (ahb_m2s_i.htrans == NONSEQ))
    else $error("htrans is neither IDLE nor NONSEQ");

  hsize_word_a: assert property (@(posedge HCLK) disable iff (!HRESETn)
    ahb_m2s_i.hsize == HSIZE_WORD)
    else $error("hsize is not a word transfer");

  // address phase held while the bus is stalled
  addr_hold_a: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (ahb_m2s_i.htrans == NONSEQ) && !ahb_s2m_i.hready |=>
      (ahb_m2s_i.htrans == NONSEQ) && $stable(ahb_m2s_i.haddr))
    else $error("address phase changed during a wait state");

  tx_hold_a: assert property (@(posedge HCLK) disable iff (!HRESETn)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_data_i))
    else $error("tx byte dropped or changed before it was accepted");

endmodule

`default_nettype wire

// File: adp_cmd_parser.sv
//------------------------------------------------
// Command parser: turns received characters into
// a decoded command with an optional hex parameter
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module adp_cmd_parser (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  input  wire adp_pkg::char_t      rx_data_i,
  input  wire                      rx_valid_i,
  input  wire                      line_done_i,
  output logic                     rx_ready_o,
  output adp_pkg::adp_cmd_t        cmd_o,
  output logic                     cmd_stb_o
);
  import adp_pkg::*;

  typedef enum logic [1:0] {CMD_WAIT, PARAM, ISSUE, BLOCKED} state_e;

  state_e   state_q;
  adp_cmd_t cmd_q;
  logic     rx_take;

  function automatic logic is_eol(input char_t c);
    return (c == CH_LF) || (c == CH_CR);
  endfunction

  function automatic logic is_blank(input char_t c);
    return (c == CH_SPACE) || (c == CH_TAB);
  endfunction

  function automatic logic is_hex(input char_t c);
    return ((c >= "0") && (c <= "9")) || ((c >= "a") && (c <= "f")) ||
           ((c >= "A") && (c <= "F"));
  endfunction

  function automatic logic [3:0] hex_val(input char_t c);
    char_t d;
    if (c <= "9")
      d = c - "0";
    else
      d = (c | 8'h20) - "a" + 8'd10;  // fold case first
    return d[3:0];
  endfunction

  function automatic cmd_op_e decode(input char_t c);
    case (c | 8'h20)
      "a":     return OP_A;
      "c":     return OP_C;
      "r":     return OP_R;
      "w":     return OP_W;
      default: return OP_BAD;
    endcase
  endfunction

  function automatic char_t to_upper(input char_t c);
    return c[6] ? (c & 8'h5f) : c;
  endfunction

  assign rx_ready_o = (state_q == CMD_WAIT) || (state_q == PARAM);
  assign rx_take    = rx_valid_i && rx_ready_o;
  assign cmd_stb_o  = (state_q == ISSUE);
  assign cmd_o      = cmd_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= BLOCKED;  // held off until the first prompt is out
    end else begin
      case (state_q)
        CMD_WAIT: begin
          if (rx_take && !is_blank(rx_data_i))
            state_q <= is_eol(rx_data_i) ? ISSUE : PARAM;
        end
        PARAM: begin
          if (rx_take && is_eol(rx_data_i))
            state_q <= ISSUE;
        end
        ISSUE:   state_q <= BLOCKED;  // one-cycle strobe
        BLOCKED: begin
          if (line_done_i)
            state_q <= CMD_WAIT;
        end
        default: state_q <= BLOCKED;
      endcase
    end
  end

  // command record, loaded as characters arrive
  always_ff @(posedge HCLK) begin
    if (rx_take) begin
      if (state_q == CMD_WAIT) begin
        if (is_eol(rx_data_i)) begin  // empty line
          cmd_q.op        <= OP_BAD;
          cmd_q.letter    <= CH_UNKNOWN;
          cmd_q.has_param <= 1'b0;
          cmd_q.param     <= '0;
        end else if (!is_blank(rx_data_i)) begin
          cmd_q.op        <= decode(rx_data_i);
          cmd_q.letter    <= to_upper(rx_data_i);
          cmd_q.has_param <= 1'b0;
          cmd_q.param     <= '0;
        end
      end else if (is_hex(rx_data_i)) begin
        cmd_q.param     <= {cmd_q.param[27:0], hex_val(rx_data_i)};
        cmd_q.has_param <= 1'b1;
      end else if (is_blank(rx_data_i) || ((rx_data_i | 8'h20) == "x")) begin
        cmd_q.param <= '0;  // new field or 0x prefix
      end
    end
  end

endmodule

`default_nettype wire

// File: adp_pkg.sv
//------------------------------------------------
// Debug protocol definitions: character codes,
// command decode and the command/response records
//------------------------------------------------
`default_nettype none

package adp_pkg;

  typedef logic [7:0] char_t;  // one protocol character
  typedef logic [7:0] gpio_t;  // GPO / GPI byte

  //------------------------------------------------
  // character codes
  //------------------------------------------------
  localparam char_t CH_LF      = 8'h0a;
  localparam char_t CH_CR      = 8'h0d;
  localparam char_t CH_SPACE   = 8'h20;
  localparam char_t CH_TAB     = 8'h09;
  localparam char_t CH_ERR     = 8'h21;  // "!" replaces the separator
  localparam char_t CH_UNKNOWN = 8'h3f;  // "?" answer to a bad line

  typedef enum logic [2:0] {
    OP_A,    // set or report address
    OP_C,    // GPO control
    OP_R,    // read word, address++
    OP_W,    // write word, address++
    OP_BAD   // unknown letter or empty line
  } cmd_op_e;

  // upper part of the C parameter
  // 1 clears bits, 2 sets bits, 3 overwrites, others only report
  typedef logic [23:0] ctl_sel_t;

  typedef struct packed {
    cmd_op_e         op;
    char_t           letter;     // upper case echo
    logic            has_param;  // at least one hex digit seen
    ahb_pkg::hword_t param;
  } adp_cmd_t;

  typedef struct packed {
    char_t           letter;
    logic            err;        // bus error on R or W
    ahb_pkg::hword_t word;
  } adp_rsp_t;

endpackage

`default_nettype wire

// File: adp_resp_formatter.sv
//------------------------------------------------
// Response formatter: sends the report line, the
// line end and the prompt on the transmit stream
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module adp_resp_formatter #(
  parameter adp_pkg::char_t PROMPT_CHAR = "]"
) (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  input  wire adp_pkg::adp_rsp_t   rsp_i,
  input  wire                      rsp_stb_i,
  input  wire                      tx_ready_i,
  output adp_pkg::char_t           tx_data_o,
  output logic                     tx_valid_o,
  output logic                     line_done_o
);
  import adp_pkg::*;

  typedef enum logic [3:0] {
    START_PROMPT, LETTER, SEP, ZERO, X, NIBBLE, LF, CR, PROMPT, IDLE
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic       valid_q;
  logic [2:0] nib_q;      // 0 = most significant digit
  logic       line_done_q;
  logic       tx_take;
  logic [3:0] nibble;

  function automatic char_t hex_char(input logic [3:0] n);
    return (n < 4'd10) ? {4'h3, n} : (8'h57 + {4'h0, n});  // lower case a-f
  endfunction

  assign tx_take = valid_q && tx_ready_i;
  assign nibble  = rsp_i.word[{~nib_q, 2'b00} +: 4];

  always_comb begin
    case (state_q)
      LETTER:  tx_data_o = rsp_i.letter;
      SEP:     tx_data_o = rsp_i.err ? CH_ERR : CH_SPACE;
      ZERO:    tx_data_o = "0";
      X:       tx_data_o = "x";
      NIBBLE:  tx_data_o = hex_char(nibble);
      LF:      tx_data_o = CH_LF;
      CR:      tx_data_o = CH_CR;
      default: tx_data_o = PROMPT_CHAR;  // both prompt states
    endcase
  end

  //------------------------------------------------
  // byte sequencer, advances on each accepted byte
  //------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (rsp_stb_i)
          state_d = LETTER;
      end
      LETTER: begin
        if (tx_take)  // "?" goes straight to the line end
          state_d = (rsp_i.letter == CH_UNKNOWN) ? LF : SEP;
      end
      SEP:    if (tx_take) state_d = ZERO;
      ZERO:   if (tx_take) state_d = X;
      X:      if (tx_take) state_d = NIBBLE;
      NIBBLE: if (tx_take && (nib_q == 3'd7)) state_d = LF;
      LF:     if (tx_take) state_d = CR;
      CR:     if (tx_take) state_d = PROMPT;
      default: begin
        if (tx_take)
          state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q     <= START_PROMPT;
      valid_q     <= 1'b0;
      nib_q       <= '0;
      line_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      valid_q     <= (state_d != IDLE);
      // each prompt releases the parser for the next line
      line_done_q <= tx_take && ((state_q == PROMPT) || (state_q == START_PROMPT));
      if (tx_take && (state_q == NIBBLE))
        nib_q <= nib_q + 3'd1;  // wraps to 0 after the last digit
    end
  end

  assign tx_valid_o  = valid_q;
  assign line_done_o = line_done_q;

endmodule

`default_nettype wire

// File: adp_tb.sv
//------------------------------------------------
// Testbench for the debug protocol controller:
// command table, AHB memory model with wait states
// and random transmit back-pressure
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module adp_tb;
  import ahb_pkg::*;
  import adp_pkg::*;

  localparam char_t PROMPT          = "]";
  localparam int    NUM_TESTS       = 18;
  localparam int    WATCHDOG_CYCLES = (NUM_TESTS + 1) * 3000;

  logic     HCLK;
  logic     HRESETn;
  char_t    rx_data  = '0;
  logic     rx_valid = 1'b0;
  logic     rx_ready;
  char_t    tx_data;
  logic     tx_valid;
  logic     tx_ready = 1'b0;
  ahb_m2s_t ahb_m2s;
  ahb_s2m_t ahb_s2m  = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
  gpio_t    gpo;
  gpio_t    gpi      = 8'h5c;

  logic [31:0] lfsr_q = 32'h1a95d907;
  hword_t      mem [haddr_t];           // sparse AHB memory
  logic        in_dp    = 1'b0;         // data phase pending
  logic [2:0]  low_left = '0;
  haddr_t      dp_addr  = '0;
  logic        dp_write = 1'b0;
  logic        dp_err   = 1'b0;
  char_t       tx_q [$];                // bytes seen on the tx stream
  char_t       got_q [$];
  int          pass_count = 0;
  int          fail_count = 0;

  // command text, report text without the line end, expected gpo (-1 = skip)
  string cmd_tab [NUM_TESTS] = '{
    "A 100", "W 0x12345678", "w cafe", "a 100", "r", "R", "r", "A",
    "A F0000000", "W 55", "R", "C 3A5", "C 10F", "C 2F0", "C", "Z 12", "", "  a"
  };
  string exp_tab [NUM_TESTS] = '{
    "A 0x00000100", "W 0x12345678", "W 0x0000cafe", "A 0x00000100",
    "R 0x12345678", "R 0x0000cafe", "R 0x0108ffff", "A 0x0000010c",
    "A 0xf0000000", "W!0x00000055", "R!0x00000000", "C 0x5ca503a5",
    "C 0x5ca0010f", "C 0x5cf002f0", "C 0x5cf00000", "?", "?", "A 0xf0000008"
  };
  int gpo_tab [NUM_TESTS] = '{
    -1, -1, -1, -1, -1, -1, -1, -1, -1, -1, -1, 'ha5, 'ha0, 'hf0, 'hf0, -1, -1, -1
  };

  tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clkgen (
    .hclk_o    (HCLK),
    .hresetn_o (HRESETn)
  );

  adp_top #(.PROMPT_CHAR(PROMPT)) u_dut (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .rx_ready_o (rx_ready),
    .tx_data_o  (tx_data),
    .tx_valid_o (tx_valid),
    .tx_ready_i (tx_ready),
    .ahb_o      (ahb_m2s),
    .ahb_i      (ahb_s2m),
    .gpo_o      (gpo),
    .gpi_i      (gpi)
  );

  bind adp_top adp_chk u_chk (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .ahb_m2s_i  (ahb_o),
    .ahb_s2m_i  (ahb_i),
    .tx_data_i  (tx_data_o),
    .tx_valid_i (tx_valid_o),
    .tx_ready_i (tx_ready_i)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[2:0], lfsr_q[0]};
    end
  endtask

  // unwritten words show every address bit
  function automatic hword_t fill_word(input haddr_t a);
    return {a[15:0], ~a[31:16]};
  endfunction

  function automatic hword_t read_word(input haddr_t a);
    if (mem.exists(a))
      return mem[a];
    return fill_word(a);
  endfunction

  //------------------------------------------------
  // AHB memory model and tx back-pressure
  //------------------------------------------------
  always @(posedge HCLK) begin
    logic [3:0] bits;
    logic [2:0] low;
    logic       err;
    if (!HRESETn) begin
      ahb_s2m.hready <= 1'b1;
      ahb_s2m.hresp  <= 1'b0;
      tx_ready       <= 1'b0;
      in_dp          <= 1'b0;
    end else begin
      take_bits(2, bits);
      tx_ready <= (bits[1:0] != 2'b11);  // low about a quarter of the time
      if (in_dp && ahb_s2m.hready) begin  // data phase ends here
        if (dp_write && !dp_err)
          mem[dp_addr] = ahb_m2s.hwdata;
        in_dp         <= 1'b0;
        ahb_s2m.hresp <= 1'b0;
      end else if (in_dp) begin
        if (low_left == 3'd0) begin
          ahb_s2m.hready <= 1'b1;
          ahb_s2m.hresp  <= dp_err;
          ahb_s2m.hrdata <= dp_err ? '0 : read_word(dp_addr);
        end else begin
          low_left      <= low_left - 3'd1;
          ahb_s2m.hresp <= dp_err && (low_left == 3'd1);  // first error cycle
        end
      end
      if ((ahb_m2s.htrans == NONSEQ) && ahb_s2m.hready) begin
        take_bits(2, bits);
        err      = (ahb_m2s.haddr[31:28] == 4'hf);
        low      = {1'b0, bits[1:0]} + {2'b00, err};
        dp_addr  <= ahb_m2s.haddr;
        dp_write <= ahb_m2s.hwrite;
        dp_err   <= err;
        in_dp    <= 1'b1;
        if (low == 3'd0) begin
          ahb_s2m.hready <= 1'b1;
          ahb_s2m.hresp  <= 1'b0;
          ahb_s2m.hrdata <= read_word(ahb_m2s.haddr);
        end else begin
          ahb_s2m.hready <= 1'b0;
          ahb_s2m.hresp  <= err && (low == 3'd1);
          low_left       <= low - 3'd1;
        end
      end else if (!in_dp) begin
        take_bits(2, bits);
        ahb_s2m.hready <= (bits[1:0] != 2'b00);  // shared HREADY held by another slave
      end
    end
  end

  // mid-cycle sample of the tx handshake
  always @(negedge HCLK) begin
    if (HRESETn && tx_valid && tx_ready)
      tx_q.push_back(tx_data);
  end

  task automatic send_line(input string text);
    for (int i = 0; i <= text.len(); i++) begin
      @(posedge HCLK);
      rx_data  <= (i < text.len()) ? char_t'(text[i]) : CH_CR;
      rx_valid <= 1'b1;
      @(negedge HCLK);
      while (!rx_ready)
        @(negedge HCLK);
    end
    @(posedge HCLK);  // last byte taken here
    rx_valid <= 1'b0;
  endtask

  task automatic collect_line();
    char_t c;
    bit    done;
    got_q = {};
    done  = 1'b0;
    while (!done) begin
      @(posedge HCLK);
      while ((tx_q.size() > 0) && !done) begin
        c = tx_q.pop_front();
        got_q.push_back(c);
        done = (c == PROMPT);
      end
    end
  endtask

  // report text, then LF, CR and the prompt
  function automatic bit line_matches(input string rpt);
    int n;
    n = rpt.len();
    if (got_q.size() != n + 3)
      return 1'b0;
    for (int i = 0; i < n; i++) begin
      if (got_q[i] != char_t'(rpt[i]))
        return 1'b0;
    end
    return (got_q[n] == CH_LF) && (got_q[n+1] == CH_CR) && (got_q[n+2] == PROMPT);
  endfunction

  function automatic string show_bytes();
    string s;
    s = "";
    foreach (got_q[i]) begin
      if (got_q[i] == CH_LF)
        s = {s, "<lf>"};
      else if (got_q[i] == CH_CR)
        s = {s, "<cr>"};
      else
        s = {s, $sformatf("%c", got_q[i])};
    end
    return s;
  endfunction

  task automatic tally(input int idx, input string label, input bit ok);
    if (ok)
      pass_count++;
    else
      fail_count++;
    $display("test %0d %s : %s", idx, label, ok ? "ok" : "fail");
  endtask

  //------------------------------------------------
  // main sequence
  //------------------------------------------------
  initial begin
    bit ok;
    $timeformat(-9, 1, " ns", 0);
    @(posedge HRESETn);
    collect_line();
    ok = (got_q.size() == 1) && (got_q[0] == PROMPT);
    if (!ok)
      $display("[ERROR] %t: after reset expected a lone prompt, got \"%s\"", $realtime,
               show_bytes());
    tally(0, "reset prompt", ok);
    for (int i = 0; i < NUM_TESTS; i++) begin
      send_line(cmd_tab[i]);
      collect_line();
      ok = line_matches(exp_tab[i]);
      if (!ok)
        $display("[ERROR] %t: command \"%s\" expected \"%s<lf><cr>%c\", got \"%s\"",
                 $realtime, cmd_tab[i], exp_tab[i], PROMPT, show_bytes());
      if ((gpo_tab[i] >= 0) && (gpo != 8'(gpo_tab[i]))) begin
        $display("[ERROR] %t: command \"%s\" expected gpo %h, got %h", $realtime,
                 cmd_tab[i], 8'(gpo_tab[i]), gpo);
        ok = 1'b0;
      end
      tally(i + 1, $sformatf("\"%s\"", cmd_tab[i]), ok);
    end
    $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge HCLK);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: adp_top.sv
//------------------------------------------------
// ASCII debug protocol controller top level
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module adp_top #(
  parameter adp_pkg::char_t PROMPT_CHAR = "]"
) (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  // receive byte stream
  input  wire adp_pkg::char_t      rx_data_i,
  input  wire                      rx_valid_i,
  output logic                     rx_ready_o,
  // transmit byte stream
  output adp_pkg::char_t           tx_data_o,
  output logic                     tx_valid_o,
  input  wire                      tx_ready_i,
  // AHB-Lite initiator
  output ahb_pkg::ahb_m2s_t        ahb_o,
  input  wire ahb_pkg::ahb_s2m_t   ahb_i,
  // GPIO
  output adp_pkg::gpio_t           gpo_o,
  input  wire adp_pkg::gpio_t      gpi_i
);
  import adp_pkg::*;

  adp_cmd_t cmd;
  logic     cmd_stb;
  adp_rsp_t rsp;
  logic     rsp_stb;
  logic     line_done;

  adp_cmd_parser u_parser (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .rx_data_i   (rx_data_i),
    .rx_valid_i  (rx_valid_i),
    .line_done_i (line_done),
    .rx_ready_o  (rx_ready_o),
    .cmd_o       (cmd),
    .cmd_stb_o   (cmd_stb)
  );

  adp_bus_engine u_engine (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .cmd_i     (cmd),
    .cmd_stb_i (cmd_stb),
    .ahb_i     (ahb_i),
    .gpi_i     (gpi_i),
    .ahb_o     (ahb_o),
    .gpo_o     (gpo_o),
    .rsp_o     (rsp),
    .rsp_stb_o (rsp_stb)
  );

  adp_resp_formatter #(
    .PROMPT_CHAR (PROMPT_CHAR)
  ) u_fmt (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .rsp_i       (rsp),
    .rsp_stb_i   (rsp_stb),
    .tx_ready_i  (tx_ready_i),
    .tx_data_o   (tx_data_o),
    .tx_valid_o  (tx_valid_o),
    .line_done_o (line_done)
  );

endmodule

`default_nettype wire

// File: ahb_pkg.sv
//------------------------------------------------
// AHB-Lite bus types and the fixed transfer
// encodings used by the debug-protocol initiator
//------------------------------------------------
`default_nettype none

package ahb_pkg;

  typedef logic [31:0] haddr_t;  // byte address
  typedef logic [31:0] hword_t;  // data word

  // only single transfers are issued, so no BUSY or SEQ
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } htrans_e;

  localparam logic [2:0] HSIZE_WORD = 3'b010;   // 32-bit transfer
  localparam logic [3:0] HPROT_DATA = 4'b0011;  // privileged data access
  localparam haddr_t     ADDR_STEP  = 32'd4;    // one word per access

  typedef struct packed {
    haddr_t     haddr;
    htrans_e    htrans;
    logic       hwrite;
    logic [2:0] hsize;
    logic [2:0] hburst;
    logic [3:0] hprot;
    logic       hmastlock;
    hword_t     hwdata;
  } ahb_m2s_t;

  typedef struct packed {
    hword_t hrdata;
    logic   hready;
    logic   hresp;   // 1 = error
  } ahb_s2m_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the debug protocol controller testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module adp_tb -o adp_tb_sim \
  > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed"
  exit 1
fi

./obj_dir/adp_tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$SIM_LOG"; then
  exit 0
fi
exit 1

// File: tb_clkgen.sv
//------------------------------------------------
// Testbench clock and reset generator
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic hclk_o,
  output logic hresetn_o
);

  initial begin
    hclk_o = 1'b0;
    forever #(PERIOD_NS / 2) hclk_o = ~hclk_o;
  end

  initial begin
    hresetn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge hclk_o);
    hresetn_o <= 1'b1;  // released on a clock edge
  end

endmodule

`default_nettype wire

// File: vlog.f
ahb_pkg.sv
adp_pkg.sv
adp_cmd_parser.sv
adp_bus_engine.sv
adp_resp_formatter.sv
adp_top.sv
tb_clkgen.sv
adp_chk.sv
adp_tb.sv
